/* list.f */
+incdir+.
pixel_fifo_pkg.sv
async_fifo.sv
pixel_packer.sv
pixel_unpacker.sv
frame_reset_gen.sv
ddr3_fifo_ctrl.sv
tb_ddr3_fifo_ctrl.sv

/* Bender.yml */
package:
  name: ddr3_fifo_ctrl

sources:
  - include_dirs:
      - .
    files:
      - pixel_fifo_pkg.sv
      - async_fifo.sv
      - pixel_packer.sv
      - pixel_unpacker.sv
      - frame_reset_gen.sv
      - ddr3_fifo_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ddr3_fifo_ctrl.sv

/* tb_ddr3_fifo_ctrl.sv */
`timescale 1ns/10ps
`include "pixel_fifo_macros.svh"

module tb_ddr3_fifo_ctrl
    import pixel_fifo_pkg::*;
();

    localparam int WR_PERIOD   = 40;
    localparam int UI_PERIOD   = 10;
    localparam int RD_PERIOD   = 30;
    localparam int STIM_CYCLES = 800;               // wr_clk cycles over all tests with margin
    localparam int WATCHDOG_NS = STIM_CYCLES * WR_PERIOD + 10_000;
    localparam int SETTLE_MAX  = 64;                // ui_clk cycles

    logic      rst_n;
    logic      wr_clk;
    logic      rd_clk;
    logic      ui_clk;
    logic      wr_en;
    pixel_t    wrdata;
    beat_t     rfifo_din;
    logic      rdata_req;
    logic      rfifo_wren;
    logic      wfifo_rden;
    logic      rd_load;
    logic      wr_load;
    beat_t     wfifo_dout;
    fifo_cnt_t rfifo_wcount;
    fifo_cnt_t wfifo_rcount;
    pixel_t    rddata;

    integer seed = 32'hed05_e780;
    pixel_t pix_q[$];                               // accepted pixels not yet popped as beats
    beat_t  beat_q[$];                              // read FIFO contents
    int     slice;                                  // model position in the head beat

    ddr3_fifo_ctrl i_ddr3_fifo_ctrl (
        .rst_n        (rst_n),
        .wr_clk       (wr_clk),
        .rd_clk       (rd_clk),
        .ui_clk       (ui_clk),
        .wr_en        (wr_en),
        .wrdata       (wrdata),
        .rfifo_din    (rfifo_din),
        .rdata_req    (rdata_req),
        .rfifo_wren   (rfifo_wren),
        .wfifo_rden   (wfifo_rden),
        .rd_load      (rd_load),
        .wr_load      (wr_load),
        .wfifo_dout   (wfifo_dout),
        .rfifo_wcount (rfifo_wcount),
        .wfifo_rcount (wfifo_rcount),
        .rddata       (rddata)
    );

    // ****************************************
    // clocks and watchdog
    // ****************************************

    initial begin
        wr_clk = 1'b0;
        forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
    end

    initial begin
        ui_clk = 1'b0;
        forever #(UI_PERIOD / 2) ui_clk = ~ui_clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("timeout: the run did not finish within %0d ns", WATCHDOG_NS));
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "testbench stopped at the first error");
    endtask

    // ****************************************
    // reference model
    // ****************************************

    function automatic beat_t random_beat();
        beat_t b;
        for (int k = 0; k < `BEAT_W / 32; k++) begin
            b[32*k +: 32] = $random(seed);
        end
        return b;
    endfunction

    // first pixel lands in the top slice
    function automatic beat_t next_packed_beat();
        beat_t b;
        for (int j = 0; j < `PIX_PER_BEAT; j++) begin
            b[`BEAT_W-1-j*`PIX_W -: `PIX_W] = pix_q.pop_front();
        end
        return b;
    endfunction

    function automatic pixel_t next_slice();
        beat_t  head;
        pixel_t p;
        head = beat_q[0];
        p    = head[`BEAT_W-1-slice*`PIX_W -: `PIX_W];
        slice++;
        if (slice == `PIX_PER_BEAT) begin
            void'(beat_q.pop_front());              // popped with its last slice
            slice = 0;
        end
        return p;
    endfunction

    // ****************************************
    // stimulus and checks
    // ****************************************

    task automatic write_pixels(input int n);
        pixel_t p;
        int     sent;
        sent = 0;
        while (sent < n) begin
            @(posedge wr_clk);
            if ($unsigned($random(seed)) % 4 == 0) begin
                wr_en <= 1'b0;                      // random gap
            end else begin
                p = pixel_t'($random(seed));
                wr_en  <= 1'b1;
                wrdata <= p;
                pix_q.push_back(p);
                sent++;
            end
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
    endtask

    task automatic write_rbeats(input int n);
        beat_t b;
        int    gap;
        for (int i = 0; i < n; i++) begin
            b   = random_beat();
            gap = $unsigned($random(seed)) % 16;
            @(posedge ui_clk);
            rfifo_wren <= 1'b1;
            rfifo_din  <= b;
            beat_q.push_back(b);
            @(posedge ui_clk);
            rfifo_wren <= 1'b0;
            repeat (gap) @(posedge ui_clk);
        end
    endtask

    task automatic pop_wbeats(input int n);
        beat_t exp;
        for (int i = 0; i < n; i++) begin
            exp = next_packed_beat();
            @(negedge ui_clk);
            assert (wfifo_dout === exp) else stop_on_error($sformatf(
                "MISMATCH at time %0t: wfifo_dout %h, expected %h", $time, wfifo_dout, exp));
            @(posedge ui_clk);
            wfifo_rden <= 1'b1;
            @(posedge ui_clk);
            wfifo_rden <= 1'b0;
        end
    endtask

    // request held for n pixels, then dropped for at least one cycle
    task automatic read_run(input int n);
        pixel_t exp;
        @(posedge rd_clk);
        rdata_req <= 1'b1;
        for (int i = 0; i < n; i++) begin
            @(posedge rd_clk);
            if (i == n - 1) begin
                rdata_req <= 1'b0;
            end
            @(negedge rd_clk);
            exp = next_slice();
            assert (rddata === exp) else stop_on_error($sformatf(
                "MISMATCH at time %0t: rddata %h, expected %h", $time, rddata, exp));
        end
        slice = 0;                                  // partial beat restarts at slice 0
    endtask

    task automatic settle_levels(input int exp_w, input int exp_r);
        int n;
        n = 0;
        do begin
            @(negedge ui_clk);
            n++;
        end while ((wfifo_rcount != exp_w || rfifo_wcount != exp_r) && n < SETTLE_MAX);
        assert (wfifo_rcount == exp_w) else stop_on_error($sformatf(
            "MISMATCH at time %0t: wfifo_rcount %0d, expected %0d", $time, wfifo_rcount, exp_w));
        assert (rfifo_wcount == exp_r) else stop_on_error($sformatf(
            "MISMATCH at time %0t: rfifo_wcount %0d, expected %0d", $time, rfifo_wcount, exp_r));
    endtask

    task automatic wait_rd_visible();
        repeat (6) @(posedge rd_clk);               // pointer sync into rd_clk
    endtask

    task automatic pulse_wr_load();
        @(posedge wr_clk);
        wr_load <= 1'b1;
        repeat (`FLUSH_LEN + 6) @(posedge wr_clk);
        wr_load <= 1'b0;
        repeat (4) @(posedge wr_clk);
    endtask

    task automatic pulse_rd_load();
        @(posedge ui_clk);
        rd_load <= 1'b1;
        repeat (`FLUSH_LEN + 6) @(posedge ui_clk);
        rd_load <= 1'b0;
        repeat (4) @(posedge ui_clk);
    endtask

    // ****************************************
    // test sequence
    // ****************************************

    initial begin
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wrdata     = '0;
        rfifo_din  = '0;
        rdata_req  = 1'b0;
        rfifo_wren = 1'b0;
        wfifo_rden = 1'b0;
        rd_load    = 1'b0;
        wr_load    = 1'b0;
        slice      = 0;
        repeat (4) @(posedge wr_clk);
        rst_n <= 1'b1;

        settle_levels(0, 0);
        assert (rddata == '0) else stop_on_error($sformatf(
            "MISMATCH at time %0t: rddata %h after reset, expected 0", $time, rddata));

        write_pixels(64);                           // packing
        settle_levels(8, 0);
        pop_wbeats(8);
        settle_levels(0, 0);

        write_rbeats(2);                            // unpacking while the writer stays ahead
        wait_rd_visible();
        fork
            write_rbeats(6);
            read_run(64);
        join
        settle_levels(0, 0);

        write_rbeats(3);                            // request gaps mid-beat
        wait_rd_visible();
        for (int b = 0; b < 3; b++) begin
            read_run(1 + $unsigned($random(seed)) % 7);
            read_run(`PIX_PER_BEAT);
        end
        settle_levels(0, 0);

        write_rbeats(5);                            // levels
        write_pixels(24);
        wait_rd_visible();
        read_run(16);
        settle_levels(3, 3);
        pop_wbeats(1);
        settle_levels(2, 3);
        read_run(24);
        pop_wbeats(2);
        settle_levels(0, 0);

        write_pixels(2 * `PIX_PER_BEAT + 3);        // flush after a partial beat
        settle_levels(2, 0);
        pulse_wr_load();
        pix_q.delete();
        settle_levels(0, 0);
        write_pixels(`PIX_PER_BEAT);
        settle_levels(1, 0);
        pop_wbeats(1);

        write_rbeats(4);
        settle_levels(0, 4);
        pulse_rd_load();
        beat_q.delete();
        slice = 0;
        settle_levels(0, 0);
        write_rbeats(1);
        wait_rd_visible();
        read_run(`PIX_PER_BEAT);
        settle_levels(0, 0);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* ddr3_fifo_ctrl.sv */
`timescale 1ns/10ps
`include "pixel_fifo_macros.svh"

module ddr3_fifo_ctrl
    import pixel_fifo_pkg::*;
(
    input  logic      rst_n,
    input  logic      wr_clk,                   // pixel source clock
    input  logic      rd_clk,                   // display clock
    input  logic      ui_clk,                   // DDR3 user clock
    input  logic      wr_en,
    input  pixel_t    wrdata,
    input  beat_t     rfifo_din,                // beat read from DDR3
    input  logic      rdata_req,
    input  logic      rfifo_wren,
    input  logic      wfifo_rden,
    input  logic      rd_load,                  // display frame start
    input  logic      wr_load,                  // source frame start
    output beat_t     wfifo_dout,               // beat to write to DDR3
    output fifo_cnt_t rfifo_wcount,
    output fifo_cnt_t wfifo_rcount,
    output pixel_t    rddata
);

    beat_wr_t wfifo_wr;
    beat_wr_t rfifo_wr;
    beat_t    rfifo_head;
    logic     rfifo_empty;
    logic     rfifo_rden;
    logic     wr_flush;
    logic     rd_flush;
    logic     wfifo_rst_n;
    logic     rfifo_rst_n;

    // ****************************************
    // frame flush
    // ****************************************

    frame_reset_gen i_wr_reset_gen (
        .clk   (wr_clk),
        .rst_n (rst_n),
        .load  (wr_load),
        .flush (wr_flush)
    );

    frame_reset_gen i_rd_reset_gen (
        .clk   (ui_clk),
        .rst_n (rst_n),
        .load  (rd_load),
        .flush (rd_flush)
    );

    assign wfifo_rst_n = rst_n && !wr_flush;
    assign rfifo_rst_n = rst_n && !rd_flush;

    // ****************************************
    // write path from wr_clk to ui_clk
    // ****************************************

    pixel_packer i_pixel_packer (
        .wr_clk (wr_clk),
        .rst_n  (rst_n),
        .flush  (wr_flush),
        .wr_en  (wr_en),
        .wrdata (wrdata),
        .beat   (wfifo_wr)
    );

    async_fifo #(
        .AW (`FIFO_AW)
    ) i_wfifo (
        .wr_clk   (wr_clk),
        .rd_clk   (ui_clk),
        .rst_n    (wfifo_rst_n),
        .wr       (wfifo_wr),
        .rd_en    (wfifo_rden),
        .dout     (wfifo_dout),
        .empty    (),
        .full     (),
        .wr_count (),
        .rd_count (wfifo_rcount)
    );

    // ****************************************
    // read path from ui_clk to rd_clk
    // ****************************************

    assign rfifo_wr.en   = rfifo_wren;
    assign rfifo_wr.data = rfifo_din;

    async_fifo #(
        .AW (`FIFO_AW)
    ) i_rfifo (
        .wr_clk   (ui_clk),
        .rd_clk   (rd_clk),
        .rst_n    (rfifo_rst_n),
        .wr       (rfifo_wr),
        .rd_en    (rfifo_rden),
        .dout     (rfifo_head),
        .empty    (rfifo_empty),
        .full     (),
        .wr_count (rfifo_wcount),
        .rd_count ()
    );

    pixel_unpacker i_pixel_unpacker (
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .rdata_req (rdata_req),
        .head      (rfifo_head),
        .empty     (rfifo_empty),
        .rd_en     (rfifo_rden),
        .rddata    (rddata)
    );

endmodule

/* frame_reset_gen.sv */
`timescale 1ns/10ps
`include "pixel_fifo_macros.svh"

module frame_reset_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    output logic flush
);

    localparam int CW = $clog2(`FLUSH_LEN);

    logic [2:0]    load_hist;                   // meta, sync, previous
    logic          load_rise;
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_hist <= '0;
        end else begin
            load_hist <= {load_hist[1:0], load};
        end
    end

    assign load_rise = load_hist[1] && !load_hist[2];

    // ****************************************
    // flush pulse
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            flush <= 1'b0;
        end else if (load_rise) begin
            cnt   <= CW'(`FLUSH_LEN - 1);
            flush <= 1'b1;                      // drives the async FIFO resets
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            flush <= 1'b0;
        end
    end

    a_flush_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(flush) |-> flush [*`FLUSH_LEN] ##1 !flush)
        else $error("frame_reset_gen: flush pulse length differs from FLUSH_LEN");

endmodule

/* pixel_unpacker.sv */
`timescale 1ns/10ps
`include "pixel_fifo_macros.svh"

module pixel_unpacker
    import pixel_fifo_pkg::*;
(
    input  logic   rd_clk,
    input  logic   rst_n,
    input  logic   rdata_req,
    input  beat_t  head,
    input  logic   empty,
    output logic   rd_en,
    output pixel_t rddata
);

    localparam slice_idx_t LAST = slice_idx_t'(`PIX_PER_BEAT - 1);

    pixel_t [`PIX_PER_BEAT-1:0] slices;         // slice LAST is the first pixel
    slice_idx_t                 idx;

    assign slices = head;

    // pop the head beat together with its last slice
    assign rd_en = rdata_req && !empty && (idx == LAST);

    // ****************************************
    // slice select
    // ****************************************

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            idx    <= '0;
            rddata <= '0;
        end else if (!rdata_req) begin
            idx <= '0;                          // partial beat restarts at slice 0
        end else if (!empty) begin
            rddata <= slices[LAST - idx];       // most significant first
            idx    <= (idx == LAST) ? '0 : idx + 1'b1;
        end
    end

    // the head beat has to hold until its last slice pops it
    a_head_stable: assert property (@(posedge rd_clk) disable iff (!rst_n)
        (!empty && !rd_en) |=> (empty || $stable(head)))
        else $error("pixel_unpacker: head beat changed before it was popped");

endmodule

/* pixel_packer.sv */
`timescale 1ns/10ps
`include "pixel_fifo_macros.svh"

module pixel_packer
    import pixel_fifo_pkg::*;
(
    input  logic     wr_clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     wr_en,
    input  pixel_t   wrdata,
    output beat_wr_t beat
);

    localparam slice_idx_t LAST = slice_idx_t'(`PIX_PER_BEAT - 1);

    beat_t      shift_q;                        // pixels shift in from the bottom
    slice_idx_t pix_cnt;
    logic       wr_q;

    // ****************************************
    // pixel shift register
    // ****************************************

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            shift_q <= {shift_q[`BEAT_W-`PIX_W-1:0], wrdata};
        end
    end

    // ****************************************
    // beat counter and write strobe
    // ****************************************

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
            wr_q    <= 1'b0;
        end else if (flush) begin
            pix_cnt <= '0;                      // realign to a beat boundary
            wr_q    <= 1'b0;
        end else begin
            wr_q <= wr_en && (pix_cnt == LAST); // one cycle after the eighth pixel
            if (wr_en) begin
                pix_cnt <= (pix_cnt == LAST) ? '0 : pix_cnt + 1'b1;
            end
        end
    end

    // register already holds all eight pixels while the strobe is high
    assign beat.en   = wr_q;
    assign beat.data = shift_q;

endmodule

/* async_fifo.sv */
`timescale 1ns/10ps
`include "pixel_fifo_macros.svh"

module async_fifo
    import pixel_fifo_pkg::*;
#(
    parameter int AW = `FIFO_AW
) (
    input  logic      wr_clk,
    input  logic      rd_clk,
    input  logic      rst_n,
    input  beat_wr_t  wr,
    input  logic      rd_en,
    output beat_t     dout,
    output logic      empty,
    output logic      full,
    output fifo_cnt_t wr_count,
    output fifo_cnt_t rd_count
);

    localparam int DEPTH = 1 << AW;

    typedef logic [AW:0] ptr_t;             // wrap bit on top

    beat_t      mem [DEPTH];
    logic [1:0] wr_rst_sync;
    logic [1:0] rd_rst_sync;
    logic       wr_rst_n;
    logic       rd_rst_n;
    ptr_t       wr_bin;
    ptr_t       wr_gray;
    ptr_t       rd_bin;
    ptr_t       rd_gray;
    ptr_t       rd_gray_w1;                 // read pointer seen by writer
    ptr_t       rd_gray_w2;
    ptr_t       wr_gray_r1;                 // write pointer seen by reader
    ptr_t       wr_gray_r2;
    ptr_t       rd_bin_w;
    ptr_t       wr_bin_r;
    logic       wr_push;
    logic       rd_pop;

    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // ****************************************
    // reset synchronizers
    // ****************************************

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_rst_sync <= '0;
        end else begin
            wr_rst_sync <= {wr_rst_sync[0], 1'b1};
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_rst_sync <= '0;
        end else begin
            rd_rst_sync <= {rd_rst_sync[0], 1'b1};
        end
    end

    assign wr_rst_n = wr_rst_sync[1];
    assign rd_rst_n = rd_rst_sync[1];

    // ****************************************
    // write domain
    // ****************************************

    assign wr_push = wr.en && !full;            // beats past full are dropped

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[AW-1:0]] <= wr.data;
        end
    end

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
            if (wr_push) begin
                wr_bin  <= wr_bin + 1'b1;
                wr_gray <= bin2gray(wr_bin + 1'b1);
            end
        end
    end

    // full when the two top gray bits differ and the rest match
    assign full     = (wr_gray == {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});
    assign rd_bin_w = gray2bin(rd_gray_w2);
    assign wr_count = fifo_cnt_t'(wr_bin - rd_bin_w);

    // ****************************************
    // read domain
    // ****************************************

    assign rd_pop = rd_en && !empty;

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
            if (rd_pop) begin
                rd_bin  <= rd_bin + 1'b1;
                rd_gray <= bin2gray(rd_bin + 1'b1);
            end
        end
    end

    assign empty    = (rd_gray == wr_gray_r2);
    assign wr_bin_r = gray2bin(wr_gray_r2);
    assign rd_count = fifo_cnt_t'(wr_bin_r - rd_bin);
    assign dout     = mem[rd_bin[AW-1:0]];      // show-ahead head beat

    a_no_write_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
        wr.en |-> !full)
        else $error("async_fifo: write while full, beat dropped");

    a_no_read_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        rd_en |-> !empty)
        else $error("async_fifo: read while empty");

endmodule

/* pixel_fifo_pkg.sv */
`include "pixel_fifo_macros.svh"

package pixel_fifo_pkg;

    // ****************************************
    // vector types
    // ****************************************

    typedef logic [`PIX_W-1:0]  pixel_t;       // RGB565
    typedef logic [`BEAT_W-1:0] beat_t;        // first pixel in the top slice
    typedef logic [`CNT_W-1:0]  fifo_cnt_t;    // FIFO fill level

    // index of a pixel inside a beat
    typedef logic [$clog2(`PIX_PER_BEAT)-1:0] slice_idx_t;

    // ****************************************
    // bundles
    // ****************************************

    // one write request into an async_fifo
    typedef struct packed {
        logic  en;                             // push strobe
        beat_t data;                           // beat to store
    } beat_wr_t;

endpackage

/* pixel_fifo_macros.svh */
`ifndef PIXEL_FIFO_MACROS_SVH
`define PIXEL_FIFO_MACROS_SVH

// ****************************************
// data widths
// ****************************************

`define PIX_W         16                // one RGB565 pixel
`define BEAT_W        128               // DDR3 user data beat
`define PIX_PER_BEAT  8                 // pixels packed per beat

// ****************************************
// FIFO geometry
// ****************************************

`define FIFO_AW       9                 // 512 entries
`define CNT_W         (`FIFO_AW + 1)    // level needs one extra bit for full

// ****************************************
// frame flush
// ****************************************

// long enough for both reset synchronizers of a FIFO to settle
`define FLUSH_LEN     14                // pulse length in cycles

`endif
